/* carPathTb.sv */
`timescale 1ns/1ps
`include "car_consts.svh"

module carPathTb;
    import uartPkg::*;
    import carPkg::*;

    localparam int bitClks     = `OVERSAMPLE * `BAUD_DIV; // clk per serial bit
    localparam int pwmClks     = `PWM_PERIOD * `STEP_DIV; // clk per PWM period
    localparam int timeoutClks = 2000;

    // Bad entries go out once with a low stop bit before the good copy
    typedef struct packed {
        logic       badStop;
        logic [7:0] data;    // {spare, dir[1:0], speed[3:0], last}
    } stimEntry_t;

    // Played entries have speed >= 4 so a full PWM window fits
    localparam stimEntry_t stimTable [`PATH_LEN] = '{
        '{1'b0, 8'h88}, // Mid with the spare bit set
        '{1'b1, 8'h2A}, // Slow and resent after a framing error
        '{1'b0, 8'h48}, // Fast
        '{1'b0, 8'hEC}, // Turn with the spare bit set
        '{1'b0, 8'h28}, // Slow
        '{1'b0, 8'h69}, // Turn and the last command
        '{1'b0, 8'h12},
        '{1'b0, 8'h35},
        '{1'b0, 8'h50},
        '{1'b0, 8'h7F},
        '{1'b0, 8'h03},
        '{1'b1, 8'h44},
        '{1'b0, 8'h21},
        '{1'b0, 8'h5E},
        '{1'b0, 8'h0B}
    };

    logic       clk;
    logic       rst;
    logic       rx;
    logic       enable;
    rxStatus_t  rxStatus;
    logic       pathReady;
    logic       playing;
    driveCmd_t  curCmd;
    motorPair_t wheels;

    int doneCount;  // Receiver pulses seen so far
    int errorCount;

    tbClock clkGen (.clk(clk));

    carPathTop dut0 (
        .clk      (clk),
        .rst      (rst),
        .rx       (rx),
        .enable   (enable),
        .rxStatus (rxStatus),
        .pathReady(pathReady),
        .playing  (playing),
        .curCmd   (curCmd),
        .wheels   (wheels)
    );

    ////////////////////////////////////////////////////////////
    // Checks and timeouts
    ////////////////////////////////////////////////////////////
    task automatic checkEq(input logic [31:0] actual, input logic [31:0] expected,
                           input string what);
        if (actual !== expected) begin
            $display("FAIL at %0t: %s (got %0h, expected %0h)", $time, what, actual, expected);
            $display("Simulation failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic timeoutFail(input string what);
        $display("Timed out after %0d cycles: %s", timeoutClks, what);
        $display("Simulation failed");
        $fatal(1, "stopped on timeout");
    endtask

    // Duty per wheel from the direction code
    function automatic int dutyFor(input logic [1:0] dir, input logic isLeft);
        case (dir)
            2'b00:   return `DUTY_MID;
            2'b01:   return `DUTY_SLOW;
            2'b10:   return `DUTY_FAST;
            default: return isLeft ? `DUTY_FAST : `DUTY_SLOW; // Turn
        endcase
    endfunction

    // Receiver pulse counter that also guards the parked state while enable is low
    always @(negedge clk) begin
        if (!rst) begin
            if (rxStatus.done) doneCount++;
            if (rxStatus.error) errorCount++;
            if (!enable) begin
                checkEq(32'(playing), 32'd0, "playing while enable low");
                checkEq(32'(wheels), 32'd0, "wheels moving while enable low");
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Serial driver
    ////////////////////////////////////////////////////////////
    task automatic sendBit(input logic level);
        rx = level;
        repeat (bitClks) @(negedge clk);
    endtask

    task automatic sendByte(input logic [7:0] data, input logic badStop);
        sendBit(1'b0);                                  // Start
        checkEq(32'(rxStatus.busy), 32'd1, "receiver not busy during a byte");
        for (int b = 0; b < `DATA_BITS; b++) sendBit(data[b]); // LSB first
        sendBit(!badStop);                              // Stop bit is low when bad
        rx = 1'b1;
    endtask

    task automatic waitIdle();
        int waited;
        waited = 0;
        while (rxStatus.busy) begin
            @(negedge clk);
            waited++;
            if (waited > timeoutClks) timeoutFail("receiver stayed busy");
        end
    endtask

    // Send one byte and check the receiver's reaction
    task automatic sendChecked(input logic [7:0] data, input logic bad);
        int doneBefore;
        int errorBefore;
        int waited;
        doneBefore  = doneCount;
        errorBefore = errorCount;
        waited      = 0;
        sendByte(data, bad);
        while (doneCount == doneBefore && errorCount == errorBefore) begin
            @(negedge clk);
            waited++;
            if (waited > timeoutClks) timeoutFail("no done or error pulse from the receiver");
        end
        waitIdle(); // Also covers the restart delay
        checkEq(32'(doneCount - doneBefore), bad ? 32'd0 : 32'd1, "done pulses per byte");
        checkEq(32'(errorCount - errorBefore), bad ? 32'd1 : 32'd0, "error pulses per byte");
        if (!bad) checkEq(32'(rxStatus.byteOut), 32'(data), "received byte");
    endtask

    // Count high cycles over one PWM period since wheels repeat inside a command
    task automatic measureWheels(input logic [1:0] dir, inout int elapsed);
        int leftHigh;
        int rightHigh;
        leftHigh  = 0;
        rightHigh = 0;
        repeat (pwmClks) begin
            @(negedge clk);
            elapsed++;
            leftHigh  += int'(wheels.left);
            rightHigh += int'(wheels.right);
        end
        checkEq(32'(leftHigh), 32'(dutyFor(dir, 1'b1) * `STEP_DIV), "left wheel high cycles");
        checkEq(32'(rightHigh), 32'(dutyFor(dir, 1'b0) * `STEP_DIV), "right wheel high cycles");
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////
    initial begin
        int        good;
        int        lastEntry;
        int        elapsed;
        int        waited;
        driveCmd_t expCmd;
        rst        = 1'b1;
        rx         = 1'b1; // Line idles high
        enable     = 1'b0;
        doneCount  = 0;
        errorCount = 0;
        good       = 0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Everything parked out of reset
        checkEq(32'(rxStatus.done), 32'd0, "done after reset");
        checkEq(32'(rxStatus.error), 32'd0, "error after reset");
        checkEq(32'(rxStatus.busy), 32'd0, "busy after reset");
        checkEq(32'(pathReady), 32'd0, "pathReady after reset");
        checkEq(32'(playing), 32'd0, "playing after reset");
        checkEq(32'(wheels), 32'd0, "wheels after reset");

        // Load the path with enable low
        for (int i = 0; i < `PATH_LEN; i++) begin
            if (stimTable[i].badStop) sendChecked(stimTable[i].data, 1'b1);
            sendChecked(stimTable[i].data, 1'b0);
            good++;
            checkEq(32'(pathReady), 32'(good == `PATH_LEN), "pathReady level");
        end

        // First entry with the last flag ends the path
        lastEntry = `PATH_LEN - 1;
        for (int i = `PATH_LEN - 1; i >= 0; i--) begin
            if (stimTable[i].data[0]) lastEntry = i;
        end

        enable = 1'b1;
        waited = 0;
        while (!playing) begin
            @(negedge clk);
            waited++;
            if (waited > timeoutClks) timeoutFail("playback did not start");
        end

        for (int i = 0; i <= lastEntry; i++) begin
            expCmd  = driveCmd_t'(stimTable[i].data[`CMD_BITS-1:0]);
            elapsed = 0;
            checkEq(32'(curCmd), 32'(expCmd), "command order");
            measureWheels(expCmd.dir, elapsed);
            while (playing && curCmd == expCmd) begin
                @(negedge clk);
                elapsed++;
                if (elapsed > timeoutClks) timeoutFail("command never ended");
            end
            // First command starts off the step grid
            if (i > 0) begin
                checkEq(32'(elapsed), 32'((int'(expCmd.speed) + 1) * `STEP_UNIT * `STEP_DIV),
                        "command hold time");
            end
            checkEq(32'(playing), 32'(i < lastEntry), "playing after command");
        end

        // Later entries must not show up once the path is over
        repeat (2 * pwmClks) begin
            @(negedge clk);
            checkEq(32'(playing), 32'd0, "playing restarted after last command");
            checkEq(32'(wheels), 32'd0, "wheels moving after path end");
            checkEq(32'(curCmd), 32'(expCmd), "command advanced past last");
        end

        $display("Simulation passed");
        $finish;
    end

endmodule

/* carPathTop.sv */
`timescale 1ns/1ps

module carPathTop (
    input  logic               clk,
    input  logic               rst,
    input  logic               rx,
    input  logic               enable,
    output uartPkg::rxStatus_t rxStatus,
    output logic               pathReady,
    output logic               playing,
    output carPkg::driveCmd_t  curCmd,
    output carPkg::motorPair_t wheels
);
    import carPkg::*;

    cmdStore_t cmdStore;
    logic      stepTick;

    // Decode
    uartRx rx0 (
        .clk   (clk),
        .rst   (rst),
        .rx    (rx),
        .status(rxStatus)
    );

    pathLoader loader0 (
        .clk      (clk),
        .rst      (rst),
        .status   (rxStatus),
        .cmdStore (cmdStore),
        .cmdCount (),          // Fill level not needed past ready
        .pathReady(pathReady)
    );

    // Execute
    pathSequencer seq0 (
        .clk      (clk),
        .rst      (rst),
        .enable   (enable),
        .cmdStore (cmdStore),
        .pathReady(pathReady),
        .curCmd   (curCmd),
        .playing  (playing),
        .stepTick (stepTick)
    );

    // Result
    motorDriver motor0 (
        .clk     (clk),
        .rst     (rst),
        .stepTick(stepTick),
        .curCmd  (curCmd),
        .playing (playing),
        .wheels  (wheels)
    );

endmodule

/* carPkg.sv */
`include "car_consts.svh"

package carPkg;

    ////////////////////////////////////////////////////////////
    // Drive commands
    ////////////////////////////////////////////////////////////

    // Direction code, names follow the duty each wheel gets
    typedef enum logic [1:0] {
        dirMid  = 2'b00, // Both wheels at mid duty
        dirSlow = 2'b01, // Both wheels slow
        dirFast = 2'b10, // Both wheels fast
        dirTurn = 2'b11  // Left fast, right slow
    } dir_t;

    // One command as it arrives in the low bits of a byte
    typedef struct packed {
        dir_t       dir;
        logic [3:0] speed; // Hold time in units, held for speed + 1
        logic       last;  // Path ends after this one
    } driveCmd_t;

    // Whole path, entry 0 plays first
    typedef driveCmd_t [`PATH_LEN-1:0] cmdStore_t;

    // Wheel enables
    typedef struct packed {
        logic left;
        logic right;
    } motorPair_t;

endpackage

/* car_consts.svh */
`ifndef CAR_CONSTS_SVH
`define CAR_CONSTS_SVH

////////////////////////////////////////////////////////////
// Serial receiver
////////////////////////////////////////////////////////////

// clk cycles per oversample tick, small for simulation
`define BAUD_DIV 4
// Oversample ticks per bit
`define OVERSAMPLE 4
// Ticks from the falling edge to mid start bit
`define START_CHECK 2
// Dead time after a framing error
`define RESTART_TICKS 8
`define DATA_BITS 8

////////////////////////////////////////////////////////////
// Path storage and playback
////////////////////////////////////////////////////////////

`define PATH_LEN 15
// Low bits of each byte that form a command
`define CMD_BITS 7
// clk cycles per step tick
`define STEP_DIV 4
// Step ticks per unit of the speed field
`define STEP_UNIT 2

// PWM, all counts in step ticks
`define PWM_PERIOD 8
`define DUTY_SLOW 2
`define DUTY_MID 3
`define DUTY_FAST 4

`endif

/* compile.f */
+incdir+.
uartPkg.sv
carPkg.sv
uartRx.sv
pathLoader.sv
pathSequencer.sv
motorDriver.sv
carPathTop.sv
tbClock.sv
carPathTb.sv

/* motorDriver.sv */
`timescale 1ns/1ps
`include "car_consts.svh"

module motorDriver (
    input  logic               clk,
    input  logic               rst,
    input  logic               stepTick,
    input  carPkg::driveCmd_t  curCmd,
    input  logic               playing,
    output carPkg::motorPair_t wheels
);
    import carPkg::*;

    localparam int pwmWidth = $clog2(`PWM_PERIOD);
    localparam logic [pwmWidth-1:0] pwmLast = pwmWidth'(`PWM_PERIOD - 1);

    logic [pwmWidth-1:0] pwmCnt;  // Shared by all three duties
    logic                slowPwm;
    logic                midPwm;
    logic                fastPwm;
    motorPair_t          route;

    assign slowPwm = (pwmCnt < `DUTY_SLOW);
    assign midPwm  = (pwmCnt < `DUTY_MID);
    assign fastPwm = (pwmCnt < `DUTY_FAST);

    ////////////////////////////////////////////////////////////
    // Direction routing
    ////////////////////////////////////////////////////////////
    always_comb begin
        case (curCmd.dir)
            dirMid:  route = '{left: midPwm, right: midPwm};
            dirSlow: route = '{left: slowPwm, right: slowPwm};
            dirFast: route = '{left: fastPwm, right: fastPwm};
            dirTurn: route = '{left: fastPwm, right: slowPwm}; // Veers right
            default: route = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pwmCnt <= '0;
            wheels <= '0;
        end else begin
            if (stepTick) pwmCnt <= (pwmCnt == pwmLast) ? '0 : pwmCnt + 1'b1;
            wheels <= playing ? route : '0; // Parked outside playback
        end
    end

endmodule

/* pathLoader.sv */
`timescale 1ns/1ps
`include "car_consts.svh"

module pathLoader (
    input  logic               clk,
    input  logic               rst,
    input  uartPkg::rxStatus_t status,
    output carPkg::cmdStore_t  cmdStore,
    output logic [3:0]         cmdCount,  // Commands stored so far
    output logic               pathReady  // All PATH_LEN entries filled
);
    import carPkg::*;

    localparam logic [3:0] lastIdx = 4'(`PATH_LEN - 1);

    logic wrEn;

    // Only good bytes count, later ones are dropped once full
    assign wrEn = status.done && !pathReady;

    ////////////////////////////////////////////////////////////
    // Command store
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (wrEn) begin
            // Top data bit is spare
            cmdStore[cmdCount] <= driveCmd_t'(status.byteOut[`CMD_BITS-1:0]);
        end
    end

    // Fill counter and ready flag
    always_ff @(posedge clk) begin
        if (rst) begin
            cmdCount  <= '0;
            pathReady <= 1'b0;
        end else if (wrEn) begin
            cmdCount <= cmdCount + 1'b1;
            if (cmdCount == lastIdx) pathReady <= 1'b1; // Same edge as final store
        end
    end

endmodule

/* pathSequencer.sv */
`timescale 1ns/1ps
`include "car_consts.svh"

module pathSequencer (
    input  logic              clk,
    input  logic              rst,
    input  logic              enable,    // Low pauses playback
    input  carPkg::cmdStore_t cmdStore,
    input  logic              pathReady,
    output carPkg::driveCmd_t curCmd,
    output logic              playing,
    output logic              stepTick   // One clk every STEP_DIV
);
    localparam int divWidth  = $clog2(`STEP_DIV);
    localparam int maxHold   = 16 * `STEP_UNIT;  // Speed field is 4 bits
    localparam int holdWidth = $clog2(maxHold);
    localparam logic [divWidth-1:0] divLast = divWidth'(`STEP_DIV - 1);
    localparam logic [3:0] lastIdx = 4'(`PATH_LEN - 1);

    logic [divWidth-1:0]  stepDiv;
    logic [3:0]           idx;      // Command being played
    logic [holdWidth-1:0] holdCnt;  // Step ticks spent on this command
    logic [holdWidth-1:0] holdLast;
    logic                 finished; // Path done, stays until reset
    logic                 endOfPath;

    assign curCmd    = cmdStore[idx];
    assign holdLast  = holdWidth'((curCmd.speed + 1) * `STEP_UNIT - 1);
    assign endOfPath = curCmd.last || (idx == lastIdx);

    ////////////////////////////////////////////////////////////
    // Step tick, free running
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            stepDiv  <= '0;
            stepTick <= 1'b0;
        end else begin
            stepTick <= (stepDiv == divLast);
            stepDiv  <= (stepDiv == divLast) ? '0 : stepDiv + 1'b1;
        end
    end

    // Playback control
    always_ff @(posedge clk) begin
        if (rst) begin
            idx      <= '0;
            holdCnt  <= '0;
            playing  <= 1'b0;
            finished <= 1'b0;
        end else if (enable) begin
            if (!playing && !finished && pathReady) begin
                idx     <= '0; // Start from the first entry
                holdCnt <= '0;
                playing <= 1'b1;
            end else if (playing && stepTick) begin
                if (holdCnt == holdLast) begin
                    holdCnt <= '0;
                    if (endOfPath) begin
                        playing  <= 1'b0;
                        finished <= 1'b1;
                    end else begin
                        idx <= idx + 1'b1;
                    end
                end else begin
                    holdCnt <= holdCnt + 1'b1;
                end
            end
        end
    end

endmodule

/* run.sh */
#!/bin/sh
# Build and run the car path testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f compile.f --top-module carPathTb -o simCarPath
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

simOut=$(./obj_dir/simCarPath 2>&1)
simStatus=$?
echo "$simOut"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if echo "$simOut" | grep -q "Simulation passed"; then
    exit 0
fi
exit 1

/* tbClock.sv */
`timescale 1ns/1ps

module tbClock #(
    parameter real periodNs = 4.0 // Full clock period
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(periodNs / 2.0) clk = ~clk; // Free running until $finish
    end

endmodule

/* uartPkg.sv */
`include "car_consts.svh"

package uartPkg;

    ////////////////////////////////////////////////////////////
    // Receiver FSM states
    ////////////////////////////////////////////////////////////
    typedef enum logic [2:0] {
        rxIdle         = 3'd0, // Line high, waiting for a start edge
        rxCheckStart   = 3'd1, // Confirm start bit at its middle
        rxReadBits     = 3'd2, // Shift in data, LSB first
        rxCheckStop    = 3'd3,
        rxDelayRestart = 3'd4, // Dead time after an error
        rxError        = 3'd5, // One cycle, drives the error pulse
        rxReceived     = 3'd6  // One cycle, drives the done pulse
    } rxState_t;

    // What the receiver reports each cycle
    typedef struct packed {
        logic [`DATA_BITS-1:0] byteOut; // Last good byte, stable after done
        logic                  done;    // Good stop bit seen
        logic                  error;   // False start or low stop bit
        logic                  busy;    // Any state but idle
    } rxStatus_t;

endpackage

/* uartRx.sv */
`timescale 1ns/1ps
`include "car_consts.svh"

module uartRx (
    input  logic               clk,
    input  logic               rst,
    input  logic               rx,     // Serial line, idles high
    output uartPkg::rxStatus_t status
);
    import uartPkg::*;

    localparam int divWidth = $clog2(`BAUD_DIV);
    localparam int cntWidth = $clog2(`RESTART_TICKS + 1);
    localparam int bitWidth = $clog2(`DATA_BITS + 1);
    localparam logic [divWidth-1:0] divLast = divWidth'(`BAUD_DIV - 1);

    rxState_t              state;
    logic [1:0]            rxSync;    // Two-flop synchronizer
    logic                  rxIn;      // Synchronized line
    logic [divWidth-1:0]   divCnt;
    logic                  tick;      // One per oversample period
    logic [cntWidth-1:0]   countdown; // Ticks until next sample point
    logic [bitWidth-1:0]   bitsLeft;
    logic [`DATA_BITS-1:0] shiftReg;
    logic [`DATA_BITS-1:0] byteReg;
    logic                  sampleNow;

    assign rxIn      = rxSync[1];
    assign tick      = (divCnt == divLast);
    assign sampleNow = (countdown == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            rxSync <= 2'b11; // Line reads idle out of reset
        end else begin
            rxSync <= {rxSync[0], rx};
        end
    end

    // Tick divider, realigned to the start edge
    always_ff @(posedge clk) begin
        if (rst || (state == rxIdle && !rxIn)) begin
            divCnt <= '0;
        end else begin
            divCnt <= tick ? '0 : divCnt + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Receive FSM
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= rxIdle;
            countdown <= '0;
            bitsLeft  <= '0;
        end else begin
            if (tick && !sampleNow) countdown <= countdown - 1'b1; // Stops at zero
            case (state)
                rxIdle: begin
                    if (!rxIn) begin
                        countdown <= cntWidth'(`START_CHECK); // Aim at mid start bit
                        state     <= rxCheckStart;
                    end
                end
                rxCheckStart: begin
                    if (sampleNow) begin
                        if (!rxIn) begin
                            countdown <= cntWidth'(`OVERSAMPLE);
                            bitsLeft  <= bitWidth'(`DATA_BITS);
                            state     <= rxReadBits;
                        end else begin
                            state <= rxError; // Glitch, not a start bit
                        end
                    end
                end
                rxReadBits: begin
                    if (sampleNow) begin
                        countdown <= cntWidth'(`OVERSAMPLE);
                        bitsLeft  <= bitsLeft - 1'b1;
                        if (bitsLeft == bitWidth'(1)) state <= rxCheckStop;
                    end
                end
                rxCheckStop: begin
                    if (sampleNow) state <= rxIn ? rxReceived : rxError;
                end
                rxError: begin
                    countdown <= cntWidth'(`RESTART_TICKS);
                    state     <= rxDelayRestart;
                end
                rxDelayRestart: if (sampleNow) state <= rxIdle;
                rxReceived:     state <= rxIdle;
                default:        state <= rxIdle;
            endcase
        end
    end

    // Data path, LSB arrives first
    always_ff @(posedge clk) begin
        if (state == rxReadBits && sampleNow) shiftReg <= {rxIn, shiftReg[`DATA_BITS-1:1]};
        if (state == rxCheckStop && sampleNow && rxIn) byteReg <= shiftReg; // Held until next good byte
    end

    always_comb begin
        status.byteOut = byteReg;
        status.done    = (state == rxReceived);
        status.error   = (state == rxError);
        status.busy    = (state != rxIdle);
    end

endmodule
